//--- vlog.f
+incdir+include
rtl/timer_pkg.sv
rtl/timer_reg_if.sv
rtl/timer_bus_slave.sv
rtl/timer_regs.sv
rtl/timer_channel.sv
rtl/timer_top.sv
tb/tb_timer.sv

//--- tb/timer_patterns.txt
# Columns: op adr sel data exp, numbers in hex. W write, R read (exp x = byte-lane model)
# C counter read (exp = accesses since last C, 0 = none), M compare = last C + data
# T wait data cycles, I interrupt vector must equal exp
R 0 f 0 0
R 1 f 0 0
R 4 f 0 0
R 5 f 0 0
R 6 f 0 0
R 7 f 0 0
R 8 f 0 0
R 9 f 0 0
R a f 0 0
R b f 0 0
W 0 f 12345678 0
R 0 f 0 x
W 0 5 r 0
R 0 f 0 x
W 0 f 0 0
W 1 f a5a55a5a 0
R 1 f 0 x
W 1 a r 0
R 1 f 0 x
W 1 f 0 0
W 5 f c3c3c3c3 0
R 5 f 0 x
W 5 6 r 0
R 5 f 0 x
W a f 87654321 0
R a f 0 x
W a 3 r 0
R a f 0 x
W a f 0 0
C c f 0 0
R 2 f 0 0
R 3 f 0 0
R d f 0 0
R e f 0 0
R f f 0 0
C c f 0 6
C c f 0 1
C c f 0 0
M 4 f 28 0
W 0 f 1 0
T 0 0 3c 0
R 1 f 0 1
R 8 f 0 1
C c f 0 0
M 5 f 28 0
W 0 f 3 0
T 0 0 3c 0
R 1 f 0 3
R 9 f 0 1
C c f 0 0
M 6 f 28 0
W 0 f 7 0
T 0 0 3c 0
R 1 f 0 7
R a f 0 1
C c f 0 0
M 7 f 28 0
T 0 0 3c 0
R 1 f 0 7
R b f 0 0
C c f 0 0
M 7 f 28 0
W 0 f f 0
T 0 0 3c 0
R 1 f 0 f
R b f 0 1
I 0 0 0 0
W 0 f 1f 0
I 0 0 0 8
W 0 f ff 0
I 0 0 0 f
W 0 f ef 0
I 0 0 0 7
W 1 1 e 0
R 1 f 0 e
W 0 f ff 0
I 0 0 0 7
W 1 f 0 0
R 1 f 0 0
I 0 0 0 0

//--- include/tb_timer_checks.svh
`ifndef TB_TIMER_CHECKS_SVH
`define TB_TIMER_CHECKS_SVH

  // ########################################################################
  // Compare tasks
  // ########################################################################

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_data(input string test_name, input timer_pkg::word_t expected,
                            input timer_pkg::word_t actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_irq(input string test_name, input logic [3:0] expected,
                           input logic [3:0] actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED %s: expected %b, actual %b", test_name, expected, actual);
      fail_run();
    end
  endtask

  // Ack two edges after the sampled request, for exactly one cycle
  task automatic check_ack(input string test_name, input int req_edge, input int ack_edge,
                           input int ack_cycles);
    timer_pkg::slave_state_t ack_state;
    ack_state = timer_pkg::DONE;
    if ((ack_edge - req_edge) != 2 || ack_cycles != 1)
    begin
      $display("CHECK FAILED %s: expected ack in %s after 2 edges for 1 cycle, %s",
               test_name, ack_state.name(),
               $sformatf("actual %0d edges, %0d cycles", ack_edge - req_edge, ack_cycles));
      fail_run();
    end
  endtask

`endif

//--- tb/tb_timer.sv
`timescale 1ns/10ps

module tb_timer;

  import timer_pkg::*;

  logic       clk_i;
  logic       rst_i;
  logic       cyc_i;
  logic       stb_i;
  logic       we_i;
  sel_t       sel_i;
  adr_t       adr_i;
  word_t      dat_i;
  word_t      dat_o;
  logic       ack_o;
  logic [3:0] interrupt_o;

  // Parsed script, one entry per operation
  byte   op_q [$];
  string adr_q [$];
  string sel_q [$];
  string dat_q [$];
  string exp_q [$];
  int    line_q [$];

  // Register contents as plain byte-lane writes leave them
  word_t  shadow [16];
  word_t  last_counter;
  integer seed;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  `include "tb_timer_checks.svh"

  timer_top dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .sel_i       (sel_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .interrupt_o (interrupt_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  function automatic word_t merge_lanes(input word_t old_val, input word_t new_val,
                                        input sel_t sel);
    word_t mask;
    mask = '0;
    for (int b = 0; b < SEL_W; b++)
    begin
      if (sel[b])
        mask = mask | (word_t'(32'hFF) << (8 * b));
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // ##########################################################################
  // Script loading and timeout limit
  // ##########################################################################

  task automatic load_patterns();
    int    fd;
    int    n;
    int    line_no;
    int    waits;
    int    accesses;
    byte   op;
    string line;
    string f_op;
    string f_adr;
    string f_sel;
    string f_dat;
    string f_exp;
    fd = $fopen("tb/timer_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file tb/timer_patterns.txt");
      fail_run();
    end
    line_no = 0;
    waits = 0;
    accesses = 0;
    while ($fgets(line, fd) != 0)
    begin
      line_no++;
      if (line.len() == 0 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %s %s %s %s", f_op, f_adr, f_sel, f_dat, f_exp);
      if (n <= 0)
        continue;
      op = f_op.getc(0);
      if (n != 5 || !(op inside {"W", "R", "C", "M", "T", "I"}))
      begin
        $display("Pattern line %0d is not a valid operation: %s", line_no, line);
        fail_run();
      end
      else
      begin
        if (op == "T")
          waits += f_dat.atohex();
        else if (op != "I")
          accesses++;
        op_q.push_back(op);
        adr_q.push_back(f_adr);
        sel_q.push_back(f_sel);
        dat_q.push_back(f_dat);
        exp_q.push_back(f_exp);
        line_q.push_back(line_no);
      end
    end
    $fclose(fd);
    cycle_limit = 8 + waits + 4 * accesses + 200;
  endtask

  // One bus cycle that ends at a falling edge with the strobe dropped
  task automatic bus_access(input string name, input logic we, input adr_t adr,
                            input sel_t sel, input word_t wdata, output word_t rdata);
    int req_edge;
    int ack_edge;
    int ack_cycles;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    sel_i = sel;
    dat_i = wdata;
    req_edge = cycle_cnt + 1;
    @(negedge clk_i);
    while (!ack_o)
      @(negedge clk_i);
    ack_edge = cycle_cnt + 1;
    rdata = dat_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
    ack_cycles = ack_o ? 2 : 1;
    check_ack(name, req_edge, ack_edge, ack_cycles);
  endtask

  task automatic run_patterns();
    string name;
    word_t wdata;
    word_t rdata;
    word_t expected;
    adr_t  adr;
    sel_t  sel;
    int    n_acc;
    for (int i = 0; i < op_q.size(); i++)
    begin
      name = $sformatf("line %0d %c adr %s", line_q[i], op_q[i], adr_q[i]);
      adr = adr_t'(adr_q[i].atohex());
      sel = sel_t'(sel_q[i].atohex());
      case (op_q[i])
        "W", "M":
        begin
          if (op_q[i] == "M")
            wdata = last_counter + word_t'(dat_q[i].atohex());
          else if (dat_q[i] == "r")
            wdata = $random(seed);
          else
            wdata = word_t'(dat_q[i].atohex());
          bus_access(name, 1'b1, adr, sel, wdata, rdata);
          shadow[adr] = merge_lanes(shadow[adr], wdata, sel);
        end
        "R":
        begin
          bus_access(name, 1'b0, adr, sel, '0, rdata);
          if (exp_q[i] == "x")
            expected = shadow[adr];
          else
            expected = word_t'(exp_q[i].atohex());
          check_data(name, expected, rdata);
        end
        "C":
        begin
          bus_access(name, 1'b0, adr, sel, '0, rdata);
          n_acc = exp_q[i].atohex();
          // Four cycles per access
          if (n_acc != 0)
            check_data(name, last_counter + word_t'(4 * n_acc), rdata);
          last_counter = rdata;
        end
        "T":
          repeat (dat_q[i].atohex()) @(negedge clk_i);
        default:
          check_irq(name, 4'(exp_q[i].atohex()), interrupt_o);
      endcase
    end
  endtask

  initial
  begin
    rst_i = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    sel_i = '0;
    adr_i = '0;
    dat_i = '0;
    seed  = 20;
    last_counter = '0;
    foreach (shadow[a])
      shadow[a] = '0;
    load_patterns();
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_data("reset dat_o", '0, dat_o);
    check_irq("reset interrupt_o", 4'b0000, interrupt_o);
    if (ack_o !== 1'b0)
    begin
      $display("ack_o is high right after reset");
      fail_run();
    end
    run_patterns();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- rtl/timer_top.sv
`timescale 1ns/10ps

module timer_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  timer_pkg::sel_t      sel_i,
  input  timer_pkg::adr_t      adr_i,
  input  timer_pkg::word_t     dat_i,
  output timer_pkg::word_t     dat_o,
  output logic                 ack_o,
  output logic [3:0]           interrupt_o
);

  import timer_pkg::*;

  timer_reg_if acc_bus ();

  logic [NUM_CH-1:0] ch_enable;
  logic [NUM_CH-1:0] cmp_wr;
  logic [NUM_CH-1:0] cnt_wr;
  logic [NUM_CH-1:0] ch_match;
  word_t             counter;
  sel_t              wr_sel;
  word_t             wr_data;
  word_t             ch_compare [NUM_CH];
  word_t             ch_count [NUM_CH];

  timer_bus_slave u_slave (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .sel_i (sel_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .acc   (acc_bus.slave)
  );

  timer_regs u_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .acc          (acc_bus.regs),
    .ch_enable_o  (ch_enable),
    .counter_o    (counter),
    .cmp_wr_o     (cmp_wr),
    .cnt_wr_o     (cnt_wr),
    .wr_sel_o     (wr_sel),
    .wr_data_o    (wr_data),
    .ch_compare_i (ch_compare),
    .ch_count_i   (ch_count),
    .ch_match_i   (ch_match),
    .interrupt_o  (interrupt_o)
  );

  for (genvar g = 0; g < NUM_CH; g++)
  begin : gen_ch
    timer_channel u_chan (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .enable_i  (ch_enable[g]),
      .cmp_wr_i  (cmp_wr[g]),
      .cnt_wr_i  (cnt_wr[g]),
      .sel_i     (wr_sel),
      .wdata_i   (wr_data),
      .counter_i (counter),
      .compare_o (ch_compare[g]),
      .count_o   (ch_count[g]),
      .match_o   (ch_match[g])
    );
  end

endmodule

//--- rtl/timer_channel.sv
`timescale 1ns/10ps

module timer_channel (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             enable_i,
  input  logic             cmp_wr_i,
  input  logic             cnt_wr_i,
  input  timer_pkg::sel_t  sel_i,
  input  timer_pkg::word_t wdata_i,
  input  timer_pkg::word_t counter_i,
  output timer_pkg::word_t compare_o,
  output timer_pkg::word_t count_o,
  output logic             match_o
);

  import timer_pkg::*;

  word_t compare_q;
  word_t count_q;

  // High for the single cycle where the counter hits compare
  assign match_o = enable_i && (counter_i == compare_q);

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      compare_q <= '0;
      count_q   <= '0;
    end
    else
    begin
      if (cmp_wr_i)
        compare_q <= byte_write(compare_q, wdata_i, sel_i);

      // Event increment beats a software write
      if (match_o)
        count_q <= count_q + word_t'(1);
      else if (cnt_wr_i)
        count_q <= byte_write(count_q, wdata_i, sel_i);
    end
  end

  assign compare_o = compare_q;
  assign count_o   = count_q;

endmodule

//--- rtl/timer_regs.sv
`timescale 1ns/10ps

module timer_regs (
  input  logic                                clk_i,
  input  logic                                rst_i,
  timer_reg_if.regs                           acc,
  output logic [timer_pkg::NUM_CH-1:0]        ch_enable_o,
  output timer_pkg::word_t                    counter_o,
  output logic [timer_pkg::NUM_CH-1:0]        cmp_wr_o,
  output logic [timer_pkg::NUM_CH-1:0]        cnt_wr_o,
  output timer_pkg::sel_t                     wr_sel_o,
  output timer_pkg::word_t                    wr_data_o,
  input  timer_pkg::word_t                    ch_compare_i [timer_pkg::NUM_CH],
  input  timer_pkg::word_t                    ch_count_i [timer_pkg::NUM_CH],
  input  logic [timer_pkg::NUM_CH-1:0]        ch_match_i,
  output logic [timer_pkg::NUM_CH-1:0]        interrupt_o
);

  import timer_pkg::*;

  word_t      control_q;
  word_t      status_q;
  word_t      status_d;
  word_t      counter_q;
  word_t      rdata;
  logic       wr_en;
  logic [1:0] ch_idx;

  assign wr_en  = acc.acc_stb && acc.acc_we;
  assign ch_idx = acc.acc_adr[1:0];

  // ########################################################################
  // Control, status and free counter
  // ########################################################################

  // Match pulses win over a clearing write
  always_comb
  begin
    status_d = status_q;
    if (wr_en && (acc.acc_adr == ADR_STATUS))
      status_d = byte_write(status_q, acc.acc_wdata, acc.acc_sel);
    status_d[NUM_CH-1:0] = status_d[NUM_CH-1:0] | ch_match_i;
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      control_q <= '0;
      status_q  <= '0;
      counter_q <= '0;
    end
    else
    begin
      if (wr_en && (acc.acc_adr == ADR_CONTROL))
        control_q <= byte_write(control_q, acc.acc_wdata, acc.acc_sel);
      status_q  <= status_d;
      counter_q <= counter_q + word_t'(1);
    end
  end

  // ########################################################################
  // Channel write strobes
  // ########################################################################

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      cmp_wr_o[i] = wr_en && (acc.acc_adr[3:2] == ADR_CMP_BASE[3:2]) && (ch_idx == 2'(i));
      cnt_wr_o[i] = wr_en && (acc.acc_adr[3:2] == ADR_CNT_BASE[3:2]) && (ch_idx == 2'(i));
    end
  end

  assign ch_enable_o = control_q[NUM_CH-1:0];
  assign counter_o   = counter_q;
  assign wr_sel_o    = acc.acc_sel;
  assign wr_data_o   = acc.acc_wdata;

  // ########################################################################
  // Read mux
  // ########################################################################

  always_comb
  begin
    case (acc.acc_adr)
      ADR_CONTROL: rdata = control_q;
      ADR_STATUS:  rdata = status_q;
      ADR_COUNTER: rdata = counter_q;
      default:
      begin
        if (acc.acc_adr[3:2] == ADR_CMP_BASE[3:2])
          rdata = ch_compare_i[ch_idx];
        else if (acc.acc_adr[3:2] == ADR_CNT_BASE[3:2])
          rdata = ch_count_i[ch_idx];
        else
          rdata = '0;
      end
    endcase
  end

  assign acc.acc_rdata = rdata;

  // Vector runs backwards with channel 0 on bit 3
  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
      interrupt_o[NUM_CH-1-i] = status_q[i] & control_q[NUM_CH+i];
  end

endmodule

//--- rtl/timer_bus_slave.sv
`timescale 1ns/10ps

module timer_bus_slave (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  timer_pkg::sel_t  sel_i,
  input  timer_pkg::adr_t  adr_i,
  input  timer_pkg::word_t dat_i,
  output timer_pkg::word_t dat_o,
  output logic             ack_o,
  timer_reg_if.slave       acc
);

  import timer_pkg::*;

  slave_state_t state_q;
  slave_state_t state_d;
  word_t        rdata_q;

  // ########################################################################
  // Access sequencer
  // ########################################################################

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (cyc_i && stb_i)
          state_d = BUSY;
      end
      BUSY:    state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i, posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= IDLE;
      rdata_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      // Read data held until the next read
      if (acc.acc_stb && !acc.acc_we)
        rdata_q <= acc.acc_rdata;
    end
  end

  // Master holds the request steady until ack
  assign acc.acc_stb   = (state_q == BUSY);
  assign acc.acc_we    = we_i;
  assign acc.acc_sel   = sel_i;
  assign acc.acc_adr   = adr_i;
  assign acc.acc_wdata = dat_i;

  assign dat_o = rdata_q;
  assign ack_o = (state_q == DONE);

endmodule

//--- rtl/timer_reg_if.sv
`timescale 1ns/10ps

interface timer_reg_if;

  import timer_pkg::*;

  // One register access, valid while acc_stb is high
  logic  acc_stb;
  logic  acc_we;
  sel_t  acc_sel;
  adr_t  acc_adr;
  word_t acc_wdata;
  // Combinational from acc_adr
  word_t acc_rdata;

  modport slave (
    output acc_stb,
    output acc_we,
    output acc_sel,
    output acc_adr,
    output acc_wdata,
    input  acc_rdata
  );

  modport regs (
    input  acc_stb,
    input  acc_we,
    input  acc_sel,
    input  acc_adr,
    input  acc_wdata,
    output acc_rdata
  );

endinterface

//--- rtl/timer_pkg.sv
package timer_pkg;

  // ########################################################################
  // Widths and sizes
  // ########################################################################

  localparam int DATA_W = 32;
  localparam int ADR_W  = 4;
  localparam int SEL_W  = 4;
  localparam int NUM_CH = 4;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [SEL_W-1:0]  sel_t;
  typedef logic [ADR_W-1:0]  adr_t;

  // Register map
  localparam adr_t ADR_CONTROL  = 4'h0;
  localparam adr_t ADR_STATUS   = 4'h1;
  localparam adr_t ADR_CMP_BASE = 4'h4;
  localparam adr_t ADR_CNT_BASE = 4'h8;
  localparam adr_t ADR_COUNTER  = 4'hC;

  typedef enum logic [1:0] {
    IDLE = 2'h0,
    BUSY = 2'h1,
    DONE = 2'h2
  } slave_state_t;

  // Merge write data into a word by byte lane
  function automatic word_t byte_write(input word_t old_val, input word_t new_val,
                                       input sel_t sel);
    word_t res;
    res = old_val;
    for (int b = 0; b < SEL_W; b++)
    begin
      if (sel[b])
        res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

endpackage
